// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_game_control \
		-f project.f --Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/car_collision.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module car_collision (
    input  game_pkg::pos_t i_car1_x,
    input  game_pkg::pos_t i_car1_y,
    input  game_pkg::pos_t i_car2_x,
    input  game_pkg::pos_t i_car2_y,
    output logic           o_exchange
);

    localparam int WHOLE_W = `POS_W - `FRAC_W;
    localparam int DIFF_W  = WHOLE_W + 1;
    localparam int SQ_W    = 2 * DIFF_W + 1;
    localparam logic [SQ_W-1:0] HIT_DIST_SQ = SQ_W'((2 * `CAR_RADIUS) * (2 * `CAR_RADIUS));

    logic signed [WHOLE_W-1:0] x1_whole, y1_whole, x2_whole, y2_whole;
    logic signed [DIFF_W-1:0]  dx, dy;
    logic signed [SQ_W-1:0]    dx_sq, dy_sq;
    logic        [SQ_W-1:0]    dist_sq;

    always_comb begin
        // fraction dropped
        x1_whole = $signed(i_car1_x[`POS_W-1:`FRAC_W]);
        y1_whole = $signed(i_car1_y[`POS_W-1:`FRAC_W]);
        x2_whole = $signed(i_car2_x[`POS_W-1:`FRAC_W]);
        y2_whole = $signed(i_car2_y[`POS_W-1:`FRAC_W]);
        dx       = DIFF_W'(x1_whole) - DIFF_W'(x2_whole);
        dy       = DIFF_W'(y1_whole) - DIFF_W'(y2_whole);
        dx_sq    = dx * dx;
        dy_sq    = dy * dy;
        dist_sq  = dx_sq + dy_sq;
    end

    assign o_exchange = (dist_sq < HIT_DIST_SQ);   // circles overlap

endmodule

// File: design/car_kinematics.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module car_kinematics #(
    parameter int INIT_X = 0,   // whole units
    parameter int INIT_Y = 0
) (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_frame_tick,
    input  logic           i_move_en,
    input  logic           i_collide_en,
    input  logic           i_exchange,
    input  logic [2:0]     i_acc,
    input  logic [1:0]     i_omega,          // bit0 hold, else bit1 picks +1 or -1
    input  game_pkg::vel_t i_vel_x,
    input  game_pkg::vel_t i_vel_y,
    input  game_pkg::vel_t i_other_speed,
    input  game_pkg::ang_t i_other_heading,
    output game_pkg::vel_t o_speed,
    output game_pkg::ang_t o_heading,
    output game_pkg::pos_t o_x,
    output game_pkg::pos_t o_y
);

    import game_pkg::*;

    localparam int SUM_W = `VEL_W + 2;
    localparam logic signed [SUM_W-1:0] SPEED_MAX = SUM_W'(`VEL_MAX << `FRAC_W);
    localparam ang_t HEADING_TOP = ang_t'(359);
    localparam pos_t X_MAX = pos_t'(`X_LIMIT << `FRAC_W);
    localparam pos_t Y_MAX = pos_t'(`Y_LIMIT << `FRAC_W);

    vel_t speed_r;
    ang_t heading_r;
    pos_t x_r;
    pos_t y_r;

    logic signed [SUM_W-1:0] speed_sum;
    vel_t                    speed_clamp;
    ang_t                    heading_step;
    pos_t                    x_sum;
    pos_t                    y_sum;

    function automatic pos_t clamp_pos(input pos_t v, input pos_t lim);
        if (v > lim)
            return lim;
        else if (v < -lim)
            return -lim;
        return v;
    endfunction

    always_comb begin
        // friction then throttle
        speed_sum = SUM_W'(speed_r) - SUM_W'(speed_r >>> `FRICTION_SHIFT)
                  + SUM_W'({i_acc, {`ACC_SHIFT{1'b0}}});
        if (speed_sum < 0)
            speed_clamp = '0;
        else if (speed_sum > SPEED_MAX)
            speed_clamp = vel_t'(SPEED_MAX);
        else
            speed_clamp = vel_t'(speed_sum);

        if (i_omega[0])
            heading_step = heading_r;
        else if (i_omega[1])
            heading_step = (heading_r == HEADING_TOP) ? '0 : heading_r + 1'b1;
        else
            heading_step = (heading_r == '0) ? HEADING_TOP : heading_r - 1'b1;

        x_sum = x_r + pos_t'(i_vel_x);
        y_sum = y_r + pos_t'(i_vel_y);
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            speed_r   <= '0;
            heading_r <= ang_t'(`CAR_INIT_ANGLE);
        end else if (i_frame_tick) begin
            speed_r   <= speed_clamp;
            heading_r <= heading_step;
        end else if (i_collide_en && i_exchange) begin   // equal mass swap
            speed_r   <= i_other_speed;
            heading_r <= i_other_heading;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            x_r <= pos_t'(INIT_X <<< `FRAC_W);
            y_r <= pos_t'(INIT_Y <<< `FRAC_W);
        end else if (i_move_en) begin
            x_r <= clamp_pos(x_sum, X_MAX);
            y_r <= clamp_pos(y_sum, Y_MAX);
        end
    end

    assign o_speed   = speed_r;
    assign o_heading = heading_r;
    assign o_x       = x_r;
    assign o_y       = y_r;

    // also covers speeds taken from the other car
    speed_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (speed_r >= 0) && (speed_r <= SPEED_MAX))
        else $error("speed out of range");

endmodule

// File: design/cordic_rotator.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module cordic_rotator (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_start,
    input  game_pkg::vel_t i_speed,
    input  game_pkg::ang_t i_heading,
    output game_pkg::vel_t o_vel_x,
    output game_pkg::vel_t o_vel_y,
    output logic           o_done
);

    import game_pkg::*;

    localparam int W         = `VEL_W + 2;            // headroom during iterations
    localparam int GAIN_W    = 13;
    localparam int GAIN_FRAC = 12;                    // gain constant is Q12
    localparam int PROD_W    = `VEL_W + GAIN_W;
    localparam int ITER_W    = $clog2(`CORDIC_ITERS);
    localparam logic signed [GAIN_W-1:0] GAIN_INV = GAIN_W'(`CORDIC_GAIN_INV);

    logic signed [W-1:0]      x_r;
    logic signed [W-1:0]      y_r;
    logic signed [ATAN_W-1:0] z_r;       // residual angle
    logic [ITER_W-1:0]        iter_r;
    logic                     busy_r;
    logic                     neg_r;     // result flipped for back half
    logic                     done_r;

    logic signed [PROD_W-1:0] scaled;
    logic signed [`ANG_W-1:0] z_deg;
    logic                     z_deg_neg;
    logic signed [W-1:0]      x_shift;
    logic signed [W-1:0]      y_shift;

    always_comb begin
        scaled = i_speed * GAIN_INV;
        // fold heading into -90..90
        if (i_heading >= ang_t'(270)) begin
            z_deg     = $signed(i_heading - ang_t'(360));
            z_deg_neg = 1'b0;
        end else if (i_heading > ang_t'(90)) begin
            z_deg     = $signed(i_heading - ang_t'(180));
            z_deg_neg = 1'b1;
        end else begin
            z_deg     = $signed(i_heading);
            z_deg_neg = 1'b0;
        end
        x_shift = x_r >>> iter_r;
        y_shift = y_r >>> iter_r;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy_r <= 1'b0;
            iter_r <= '0;
            neg_r  <= 1'b0;
            done_r <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (i_start) begin
                busy_r <= 1'b1;
                iter_r <= '0;
                neg_r  <= z_deg_neg;
            end else if (busy_r) begin
                iter_r <= iter_r + 1'b1;
                if (iter_r == ITER_W'(`CORDIC_ITERS - 1)) begin
                    busy_r <= 1'b0;
                    done_r <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            x_r <= W'(scaled >>> GAIN_FRAC);   // pre-scaled by 1/K
            y_r <= '0;
            z_r <= {z_deg, {`FRAC_W{1'b0}}};
        end else if (busy_r) begin
            if (!z_r[ATAN_W-1]) begin
                x_r <= x_r - y_shift;
                y_r <= y_r + x_shift;
                z_r <= z_r - ATAN_TABLE[iter_r];
            end else begin
                x_r <= x_r + y_shift;
                y_r <= y_r - x_shift;
                z_r <= z_r + ATAN_TABLE[iter_r];
            end
        end
    end

    assign o_vel_x = neg_r ? vel_t'(-x_r) : vel_t'(x_r);
    assign o_vel_y = neg_r ? vel_t'(-y_r) : vel_t'(y_r);
    assign o_done  = done_r;

    // sequencer must wait for done before the next start
    no_restart_when_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_start |-> !busy_r)
        else $error("rotator restarted mid rotation");

endmodule

// File: design/frame_timer.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module frame_timer (
    input  logic i_clk,
    input  logic i_rst_n,
    output logic o_frame_tick
);

    localparam int               CNT_W = $clog2(`FRAME_CYCLES);
    localparam logic [CNT_W-1:0] LAST  = CNT_W'(`FRAME_CYCLES - 1);

    logic [CNT_W-1:0] cnt_r;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            cnt_r        <= '0;
            o_frame_tick <= 1'b0;
        end else begin
            o_frame_tick <= (cnt_r == LAST);   // one clock per wrap
            if (cnt_r == LAST)
                cnt_r <= '0;
            else
                cnt_r <= cnt_r + 1'b1;
        end
    end

endmodule

// File: design/game_control.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module game_control (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic [2:0]                       i_car1_acc,     // 0 to 7
    input  logic [2:0]                       i_car2_acc,
    input  logic [1:0]                       i_car1_omega,
    input  logic [1:0]                       i_car2_omega,
    output game_pkg::vel_t                   o_car1_speed,
    output game_pkg::vel_t                   o_car2_speed,
    output game_pkg::ang_t                   o_car1_heading,
    output game_pkg::ang_t                   o_car2_heading,
    output logic signed [`POS_W-`FRAC_W-1:0] o_car1_x,       // whole units
    output logic signed [`POS_W-`FRAC_W-1:0] o_car1_y,
    output logic signed [`POS_W-`FRAC_W-1:0] o_car2_x,
    output logic signed [`POS_W-`FRAC_W-1:0] o_car2_y,
    output logic                             o_collide,
    output logic                             o_frame_done
);

    import game_pkg::*;

    localparam int WHOLE_W = `POS_W - `FRAC_W;

    logic frame_tick, rot_start, move_en, collide_en, exchange;
    logic car1_rot_done, car2_rot_done;
    logic collide_r;
    vel_t car1_speed, car2_speed;
    ang_t car1_heading, car2_heading;
    vel_t car1_vel_x, car1_vel_y, car2_vel_x, car2_vel_y;
    pos_t car1_x, car1_y, car2_x, car2_y;

    // round to nearest whole unit
    function automatic logic signed [WHOLE_W-1:0] round_pos(input pos_t p);
        return WHOLE_W'(p >>> `FRAC_W) + WHOLE_W'(p[`FRAC_W-1]);
    endfunction

    frame_timer u_frame_timer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .o_frame_tick (frame_tick)
    );

    physics_sequencer u_physics_sequencer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_frame_tick (frame_tick),
        .i_rot_done   (car1_rot_done & car2_rot_done),   // lockstep rotators
        .o_rot_start  (rot_start),
        .o_move_en    (move_en),
        .o_collide_en (collide_en),
        .o_frame_done (o_frame_done)
    );

    cordic_rotator u_rotate_car1 (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (rot_start),
        .i_speed   (car1_speed),
        .i_heading (car1_heading),
        .o_vel_x   (car1_vel_x),
        .o_vel_y   (car1_vel_y),
        .o_done    (car1_rot_done)
    );

    cordic_rotator u_rotate_car2 (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_start   (rot_start),
        .i_speed   (car2_speed),
        .i_heading (car2_heading),
        .o_vel_x   (car2_vel_x),
        .o_vel_y   (car2_vel_y),
        .o_done    (car2_rot_done)
    );

    car_kinematics #(
        .INIT_X (`CAR1_INIT_X),
        .INIT_Y (`CAR1_INIT_Y)
    ) u_car1 (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_frame_tick    (frame_tick),
        .i_move_en       (move_en),
        .i_collide_en    (collide_en),
        .i_exchange      (exchange),
        .i_acc           (i_car1_acc),
        .i_omega         (i_car1_omega),
        .i_vel_x         (car1_vel_x),
        .i_vel_y         (car1_vel_y),
        .i_other_speed   (car2_speed),
        .i_other_heading (car2_heading),
        .o_speed         (car1_speed),
        .o_heading       (car1_heading),
        .o_x             (car1_x),
        .o_y             (car1_y)
    );

    car_kinematics #(
        .INIT_X (`CAR2_INIT_X),
        .INIT_Y (`CAR2_INIT_Y)
    ) u_car2 (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_frame_tick    (frame_tick),
        .i_move_en       (move_en),
        .i_collide_en    (collide_en),
        .i_exchange      (exchange),
        .i_acc           (i_car2_acc),
        .i_omega         (i_car2_omega),
        .i_vel_x         (car2_vel_x),
        .i_vel_y         (car2_vel_y),
        .i_other_speed   (car1_speed),
        .i_other_heading (car1_heading),
        .o_speed         (car2_speed),
        .o_heading       (car2_heading),
        .o_x             (car2_x),
        .o_y             (car2_y)
    );

    car_collision u_car_collision (
        .i_car1_x   (car1_x),
        .i_car1_y   (car1_y),
        .i_car2_x   (car2_x),
        .i_car2_y   (car2_y),
        .o_exchange (exchange)
    );

    // held until the next frame's collide step
    always_ff @(posedge i_clk) begin
        if (!i_rst_n)
            collide_r <= 1'b0;
        else if (collide_en)
            collide_r <= exchange;
    end

    assign o_collide      = collide_r;
    assign o_car1_speed   = car1_speed;
    assign o_car2_speed   = car2_speed;
    assign o_car1_heading = car1_heading;
    assign o_car2_heading = car2_heading;
    assign o_car1_x       = round_pos(car1_x);
    assign o_car1_y       = round_pos(car1_y);
    assign o_car2_x       = round_pos(car2_x);
    assign o_car2_y       = round_pos(car2_y);

endmodule

// File: design/game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

`define FRAC_W          8       // fraction bits of position and speed
`define VEL_W           12      // signed speed word, Q4.8
`define POS_W           20      // signed position word, Q12.8
`define ANG_W           9       // heading in whole degrees
`define VEL_MAX         6       // top speed, whole units
`define FRICTION_SHIFT  4
`define ACC_SHIFT       3
`define X_LIMIT         800     // arena half width
`define Y_LIMIT         400     // arena half height
`define CAR_RADIUS      16
`define CAR1_INIT_X     (-200)
`define CAR1_INIT_Y     0
`define CAR2_INIT_X     200
`define CAR2_INIT_Y     0
`define CAR_INIT_ANGLE  0
`define FRAME_CYCLES    64      // clocks per frame
`define CORDIC_ITERS    12
`define CORDIC_GAIN_INV 2487    // 0.6073 in Q12

`endif

// File: design/game_pkg.sv
package game_pkg;

    `include "game_defs.svh"

    typedef logic signed [`VEL_W-1:0] vel_t;   // Q4.8 speed
    typedef logic signed [`POS_W-1:0] pos_t;   // Q12.8 position
    typedef logic        [`ANG_W-1:0] ang_t;   // whole degrees, 0 to 359

    // residual angle width, degrees with fraction
    localparam int ATAN_W = `ANG_W + `FRAC_W;

    // atan(2^-i) in degrees, 8 fraction bits
    localparam logic signed [ATAN_W-1:0] ATAN_TABLE [`CORDIC_ITERS] = '{
        11520, 6801, 3593, 1824,
        916,   458,  229,  115,
        57,    29,   14,   7
    };

endpackage

// File: design/physics_sequencer.sv
`timescale 1ns/1ps

module physics_sequencer (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_frame_tick,
    input  logic i_rot_done,
    output logic o_rot_start,
    output logic o_move_en,
    output logic o_collide_en,
    output logic o_frame_done
);

    typedef enum logic [1:0] {
        IDLE,
        ROTATE,
        MOVE,
        COLLIDE
    } seq_state_t;

    seq_state_t state_r;

    // each strobe fires on entry to its step
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r      <= IDLE;
            o_rot_start  <= 1'b0;
            o_move_en    <= 1'b0;
            o_collide_en <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            o_rot_start  <= 1'b0;
            o_move_en    <= 1'b0;
            o_collide_en <= 1'b0;
            o_frame_done <= 1'b0;
            unique case (state_r)
                IDLE: begin
                    if (i_frame_tick) begin   // speed and heading land this edge
                        state_r     <= ROTATE;
                        o_rot_start <= 1'b1;
                    end
                end
                ROTATE: begin
                    if (i_rot_done) begin
                        state_r   <= MOVE;
                        o_move_en <= 1'b1;
                    end
                end
                MOVE: begin
                    state_r      <= COLLIDE;
                    o_collide_en <= 1'b1;   // positions are fresh now
                end
                COLLIDE: begin
                    state_r      <= IDLE;
                    o_frame_done <= 1'b1;
                end
                default: state_r <= IDLE;
            endcase
        end
    end

    // a frame must finish well inside FRAME_CYCLES
    tick_only_in_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_frame_tick |-> (state_r == IDLE))
        else $error("frame tick while sequencer busy");

    done_only_in_rotate: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rot_done |-> (state_r == ROTATE))
        else $error("rotator done outside ROTATE");

endmodule

// File: project.f
+incdir+design
design/game_pkg.sv
design/frame_timer.sv
design/physics_sequencer.sv
design/cordic_rotator.sv
design/car_kinematics.sv
design/car_collision.sv
design/game_control.sv
testbench/tb_game_control.sv

// File: testbench/tb_game_control.sv
`timescale 1ns/1ps
`include "game_defs.svh"

module tb_game_control;

    import game_pkg::*;

    localparam int SPEED_TOP  = `VEL_MAX << `FRAC_W;
    localparam int X_MAX      = `X_LIMIT << `FRAC_W;
    localparam int Y_MAX      = `Y_LIMIT << `FRAC_W;
    localparam int HIT_SQ     = (2 * `CAR_RADIUS) * (2 * `CAR_RADIUS);
    localparam int WAIT_LIMIT = 100;   // cycles per frame wait

    logic                             clk;
    logic                             rst_n;
    logic [2:0]                       car1_acc;
    logic [2:0]                       car2_acc;
    logic [1:0]                       car1_omega;
    logic [1:0]                       car2_omega;
    vel_t                             car1_speed;
    vel_t                             car2_speed;
    ang_t                             car1_heading;
    ang_t                             car2_heading;
    logic signed [`POS_W-`FRAC_W-1:0] car1_x;
    logic signed [`POS_W-`FRAC_W-1:0] car1_y;
    logic signed [`POS_W-`FRAC_W-1:0] car2_x;
    logic signed [`POS_W-`FRAC_W-1:0] car2_y;
    logic                             collide;
    logic                             frame_done;

    // reference state, index 0 is car 1
    int     m_speed [2];
    int     m_heading [2];
    int     m_x [2];
    int     m_y [2];
    bit     m_collide;
    bit     wrap_up_seen;
    bit     wrap_down_seen;

    integer seed;
    int     checks;
    int     errors;
    int     test_err0;
    bit     aborted;

    always #2 clk = ~clk;

    game_control game_control_inst (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_car1_acc     (car1_acc),
        .i_car2_acc     (car2_acc),
        .i_car1_omega   (car1_omega),
        .i_car2_omega   (car2_omega),
        .o_car1_speed   (car1_speed),
        .o_car2_speed   (car2_speed),
        .o_car1_heading (car1_heading),
        .o_car2_heading (car2_heading),
        .o_car1_x       (car1_x),
        .o_car1_y       (car1_y),
        .o_car2_x       (car2_x),
        .o_car2_y       (car2_y),
        .o_collide      (collide),
        .o_frame_done   (frame_done)
    );

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual)
        else begin
            errors++;
            $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond)
        else begin
            errors++;
            $display("error at t=%0t: %s", $time, what);
        end
    endtask

    function automatic int clamp_pos(input int v, input int lim);
        if (v > lim)
            return lim;
        else if (v < -lim)
            return -lim;
        return v;
    endfunction

    // nearest whole unit, half rounds up
    function automatic int round_whole(input int p);
        return (p + (1 << (`FRAC_W - 1))) >>> `FRAC_W;
    endfunction

    // steering code that turns a heading toward a target by the short way
    function automatic int steer_toward(input int heading, input int target);
        int diff;
        diff = (target - heading + 360) % 360;
        if (diff == 0)
            return 1;
        else if (diff <= 180)
            return 2;
        return 0;
    endfunction

    // shift-add rotation of speed by heading
    task automatic rotate_velocity(input int speed, input int heading,
                                   output int vx, output int vy);
        int x;
        int y;
        int z;
        int x_next;
        bit flip;
        flip = 1'b0;
        if (heading >= 270) begin
            z = heading - 360;
        end else if (heading > 90) begin
            z    = heading - 180;   // back half, negate at the end
            flip = 1'b1;
        end else begin
            z = heading;
        end
        x = (speed * `CORDIC_GAIN_INV) >>> 12;
        y = 0;
        z = z <<< `FRAC_W;
        for (int i = 0; i < `CORDIC_ITERS; i++) begin
            if (z >= 0) begin
                x_next = x - (y >>> i);
                y      = y + (x >>> i);
                z      = z - int'(ATAN_TABLE[i]);
            end else begin
                x_next = x + (y >>> i);
                y      = y - (x >>> i);
                z      = z + int'(ATAN_TABLE[i]);
            end
            x = x_next;
        end
        vx = flip ? -x : x;
        vy = flip ? -y : y;
    endtask

    task automatic model_frame(input int acc1, input int acc2, input int om1, input int om2);
        int acc_v [2];
        int om_v [2];
        int s;
        int vx;
        int vy;
        int dx;
        int dy;
        int tmp;
        acc_v[0] = acc1;
        acc_v[1] = acc2;
        om_v[0]  = om1;
        om_v[1]  = om2;
        for (int c = 0; c < 2; c++) begin
            s = m_speed[c] - (m_speed[c] >>> `FRICTION_SHIFT) + (acc_v[c] << `ACC_SHIFT);
            if (s < 0)
                s = 0;
            else if (s > SPEED_TOP)
                s = SPEED_TOP;
            m_speed[c] = s;
            if ((om_v[c] & 1) != 0) begin
                m_heading[c] = m_heading[c];   // hold
            end else if ((om_v[c] & 2) != 0) begin
                if (m_heading[c] == 359)
                    m_heading[c] = 0;
                else
                    m_heading[c] = m_heading[c] + 1;
            end else begin
                if (m_heading[c] == 0)
                    m_heading[c] = 359;
                else
                    m_heading[c] = m_heading[c] - 1;
            end
            rotate_velocity(m_speed[c], m_heading[c], vx, vy);
            m_x[c] = clamp_pos(m_x[c] + vx, X_MAX);
            m_y[c] = clamp_pos(m_y[c] + vy, Y_MAX);
        end
        dx = (m_x[0] >>> `FRAC_W) - (m_x[1] >>> `FRAC_W);
        dy = (m_y[0] >>> `FRAC_W) - (m_y[1] >>> `FRAC_W);
        m_collide = (dx * dx + dy * dy) < HIT_SQ;
        if (m_collide) begin   // equal mass, swap speed and heading
            tmp          = m_speed[0];
            m_speed[0]   = m_speed[1];
            m_speed[1]   = tmp;
            tmp          = m_heading[0];
            m_heading[0] = m_heading[1];
            m_heading[1] = tmp;
        end
    endtask

    task automatic compare_outputs();
        check_value("o_car1_speed", m_speed[0], car1_speed);
        check_value("o_car2_speed", m_speed[1], car2_speed);
        check_value("o_car1_heading", m_heading[0], car1_heading);
        check_value("o_car2_heading", m_heading[1], car2_heading);
        check_value("o_car1_x", round_whole(m_x[0]), car1_x);
        check_value("o_car1_y", round_whole(m_y[0]), car1_y);
        check_value("o_car2_x", round_whole(m_x[1]), car2_x);
        check_value("o_car2_y", round_whole(m_y[1]), car2_y);
        check_value("o_collide", m_collide, collide);
    endtask

    // wrap seen on the DUT headings over one frame without a swap
    task automatic note_heading_wrap(input int prev1, input int prev2);
        if (!m_collide) begin
            if ((prev1 == 359 && car1_heading == 0) || (prev2 == 359 && car2_heading == 0))
                wrap_up_seen = 1'b1;
            if ((prev1 == 0 && car1_heading == 359) || (prev2 == 0 && car2_heading == 359))
                wrap_down_seen = 1'b1;
        end
    endtask

    task automatic wait_frame_done(output bit seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < WAIT_LIMIT) begin
            @(negedge clk);   // mid cycle, outputs settled
            seen = frame_done;
            n++;
        end
    endtask

    task automatic run_frame(input int acc1, input int acc2, input int om1, input int om2);
        bit seen;
        if (aborted)
            return;
        @(posedge clk);
        car1_acc   <= acc1[2:0];
        car2_acc   <= acc2[2:0];
        car1_omega <= om1[1:0];
        car2_omega <= om2[1:0];
        model_frame(acc1, acc2, om1, om2);
        wait_frame_done(seen);
        if (!seen) begin
            aborted = 1'b1;
            errors++;
            $display("timeout at t=%0t: no frame done within %0d cycles", $time, WAIT_LIMIT);
        end else begin
            compare_outputs();
        end
    endtask

    task automatic report_test(input string name);
        if (errors == test_err0)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - test_err0);
        test_err0 = errors;
    endtask

    initial begin
        int r;
        int target1;
        int target2;
        int hits;
        int frames;
        int prev1;
        int prev2;
        clk        = 1'b0;
        rst_n      = 1'b0;
        car1_acc   = '0;
        car2_acc   = '0;
        car1_omega = 2'b01;
        car2_omega = 2'b01;
        seed       = 32'hd02c_39ea;
        checks     = 0;
        errors     = 0;
        test_err0  = 0;
        aborted    = 1'b0;
        m_speed[0]   = 0;
        m_speed[1]   = 0;
        m_heading[0] = `CAR_INIT_ANGLE;
        m_heading[1] = `CAR_INIT_ANGLE;
        m_x[0]       = `CAR1_INIT_X <<< `FRAC_W;
        m_y[0]       = `CAR1_INIT_Y <<< `FRAC_W;
        m_x[1]       = `CAR2_INIT_X <<< `FRAC_W;
        m_y[1]       = `CAR2_INIT_Y <<< `FRAC_W;
        m_collide    = 1'b0;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_outputs();
        check_value("o_frame_done", 0, frame_done);
        report_test("reset values");

        repeat (200) begin
            r = $random(seed);
            run_frame(r[2:0], r[5:3], r[7:6], r[9:8]);
        end
        report_test("random frames");

        // full throttle settles where friction cancels the throttle step
        repeat (120) run_frame(7, 7, 1, 1);
        check_value("o_car1_speed >>> 4", 7 << `ACC_SHIFT, car1_speed >>> `FRICTION_SHIFT);
        check_value("o_car2_speed >>> 4", 7 << `ACC_SHIFT, car2_speed >>> `FRICTION_SHIFT);
        repeat (150) run_frame(0, 0, 3, 3);
        check_true(car1_speed < (1 << `FRICTION_SHIFT) && car2_speed < (1 << `FRICTION_SHIFT),
                   "speeds did not decay under zero throttle");
        report_test("speed rule");

        wrap_up_seen   = 1'b0;
        wrap_down_seen = 1'b0;
        repeat (361) begin
            prev1 = car1_heading;
            prev2 = car2_heading;
            run_frame(0, 0, 2, 2);
            note_heading_wrap(prev1, prev2);
        end
        repeat (361) begin
            prev1 = car1_heading;
            prev2 = car2_heading;
            run_frame(0, 0, 0, 0);
            note_heading_wrap(prev1, prev2);
        end
        check_true(wrap_up_seen && wrap_down_seen, "DUT heading never wrapped at 0 and 360");
        report_test("heading rule");

        // point both cars at +y and drive into the wall
        repeat (200) run_frame(0, 0, steer_toward(m_heading[0], 90),
                               steer_toward(m_heading[1], 90));
        repeat (400) run_frame(7, 7, steer_toward(m_heading[0], 90),
                               steer_toward(m_heading[1], 90));
        check_value("o_car1_y", `Y_LIMIT, car1_y);
        check_value("o_car2_y", `Y_LIMIT, car2_y);
        report_test("position rule");

        if (m_x[0] <= m_x[1]) begin
            target1 = 0;
            target2 = 180;
        end else begin
            target1 = 180;
            target2 = 0;
        end
        hits   = 0;
        frames = 0;
        while (hits == 0 && frames < 600 && !aborted) begin
            run_frame((frames < 100) ? 0 : 7, (frames < 100) ? 0 : 7,
                      steer_toward(m_heading[0], target1), steer_toward(m_heading[1], target2));
            if (m_collide)
                hits++;
            frames++;
        end
        check_true(hits > 0, "cars driven head on never collided");
        report_test("car collision");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
